// ==== all.f ====
rtl/lab1_pkg.sv
rtl/debounce.sv
rtl/rand_roller.sv
rtl/seven_hex_decoder.sv
rtl/led_display.sv
rtl/de2_115_lab1.sv
tb/tb_lab1.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_lab1
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# pass only when the run prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_lab1.sv ====
`timescale 1ns/1ps

module tb_lab1;

	localparam int DEBOUNCE_LEN  = 4;
	localparam int BASE_INTERVAL = 3;
	localparam int STEP_COUNT    = 10;
	localparam int BLINK_HALF    = 5;
	localparam int RUN_LEN       = BASE_INTERVAL * STEP_COUNT * (STEP_COUNT + 1) / 2;
	localparam int HOLD_CYCLES   = 200;
	localparam int GLITCH_WATCH  = 100;
	// three runs, two holds and the glitch watch, with about four times margin
	localparam int MAX_CYCLES    = 4 * (3 * RUN_LEN + 2 * HOLD_CYCLES + GLITCH_WATCH + 200);

	logic           i_clk = 1'b0;
	logic           i_rst_n;
	logic           i_key_start;
	logic           i_key_stop;
	lab1_pkg::seg_t o_hex0;
	lab1_pkg::seg_t o_hex1;
	logic [8:0]     o_ledg;
	logic [17:0]    o_ledr;

	int    errors = 0;
	int    tests = 0;
	int    failed = 0;
	int    err_start = 0;
	int    cycle_cnt = 0;
	int    changes = 0;
	int    toggles = 0;
	int    last_val = 0;
	int    cur_val = 0;
	int    gap = 0;
	int    step_idx = 0;
	logic  last_blink = 1'b0;
	logic  last_run = 1'b0;
	bit    watch_on = 1'b0;
	string test_name = "";

	de2_115_lab1 #(
		.DEBOUNCE_LEN  (DEBOUNCE_LEN),
		.BASE_INTERVAL (BASE_INTERVAL),
		.STEP_COUNT    (STEP_COUNT),
		.BLINK_HALF    (BLINK_HALF)
	) i_dut (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_key_start (i_key_start),
		.i_key_stop  (i_key_stop),
		.o_hex0      (o_hex0),
		.o_hex1      (o_hex1),
		.o_ledg      (o_ledg),
		.o_ledr      (o_ledr)
	);

	initial begin
		forever #4 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: run still busy after %0d cycles", MAX_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	// lit segments per digit, bit 0 = a ... bit 6 = g
	function automatic logic [6:0] lit_segments(input int digit);
		logic [6:0] lit;
		case (digit)
			0:       lit = 7'b0111111;
			1:       lit = 7'b0000110;
			2:       lit = 7'b1011011;
			3:       lit = 7'b1001111;
			4:       lit = 7'b1100110;
			5:       lit = 7'b1101101;
			6:       lit = 7'b1111101;
			7:       lit = 7'b0000111;
			8:       lit = 7'b1111111;
			9:       lit = 7'b1101111;
			default: lit = 7'b0000000;
		endcase
		return lit;
	endfunction

	function automatic int decode_digit(input logic [6:0] seg);
		int result;
		result = -1;
		for (int d = 0; d < 10; d++) begin
			if (~seg == lit_segments(d)) result = d;
		end
		return result;
	endfunction

	// -1 when the two digits do not form a legal value
	function automatic int shown_value();
		int tens;
		int ones;
		tens = decode_digit(o_hex1);
		ones = decode_digit(o_hex0);
		if (tens < 0 || tens > 1 || ones < 0) return -1;
		return tens * 10 + ones;
	endfunction

	function automatic int next_value(input int v);
		return ((v << 1) & 15) | (((v >> 3) ^ (v >> 2)) & 1);
	endfunction

	function automatic logic [17:0] thermometer(input int v);
		return 18'((1 << v) - 1);
	endfunction

	task automatic begin_test(input string name);
		test_name = name;
		err_start = errors;
		tests++;
	endtask

	task automatic end_test();
		$display("%s: finished with %0d errors", test_name, errors - err_start);
		if (errors != err_start) failed++;
	endtask

	// one clock, sampled on the falling edge where outputs are settled
	task automatic step_cycle();
		@(negedge i_clk);
		cur_val = shown_value();
		gap++;
		if (o_ledg[1] && !last_run) begin
			gap      = 0; // run starts, first wait counts from here
			step_idx = 0;
		end
		if (cur_val != last_val) begin
			changes++;
			step_idx++;
			if (watch_on && cur_val != next_value(last_val)) begin
				$display("ERROR %s: expected %0d, actual %0d", test_name,
					next_value(last_val), cur_val);
				errors++;
			end
			if (watch_on && gap != BASE_INTERVAL * step_idx) begin
				$display("ERROR %s: expected gap %0d, actual %0d", test_name,
					BASE_INTERVAL * step_idx, gap);
				errors++;
			end
			gap = 0;
		end
		if (o_ledg[8] != last_blink) toggles++;
		last_val   = cur_val;
		last_blink = o_ledg[8];
		last_run   = o_ledg[1];
		if (watch_on) begin
			if (cur_val < 0) begin
				$display("%s: display shows a pattern that is not a value", test_name);
				errors++;
			end else if (o_ledr !== thermometer(cur_val)) begin
				$display("ERROR %s: expected %h, actual %h", test_name,
					thermometer(cur_val), o_ledr);
				errors++;
			end
			if (!$onehot(o_ledg[3:0])) begin
				$display("%s: state LEDs are not one-hot (%b)", test_name, o_ledg[3:0]);
				errors++;
			end
			if (o_ledg[7:4] != 4'b0000) begin
				$display("%s: unused green LEDs are lit", test_name);
				errors++;
			end
		end
	endtask

	task automatic set_key(input bit stop_key, input logic level);
		if (stop_key) i_key_stop = level;
		else i_key_start = level;
	endtask

	// a few short bounces, then held low long enough to count as a press
	task automatic press_key(input bit stop_key);
		for (int n = 0; n < 3; n++) begin
			set_key(stop_key, 1'b0);
			repeat ($urandom_range(DEBOUNCE_LEN - 1, 1)) step_cycle();
			set_key(stop_key, 1'b1);
			repeat ($urandom_range(DEBOUNCE_LEN - 1, 1)) step_cycle();
		end
		set_key(stop_key, 1'b0);
		repeat (DEBOUNCE_LEN + 2) step_cycle();
		set_key(stop_key, 1'b1);
	endtask

	task automatic wait_state(input int idx, input int limit, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < limit && !ok; n++) begin
			step_cycle();
			if (o_ledg[idx]) ok = 1'b1;
		end
	endtask

	task automatic test_reset();
		begin_test("reset");
		if (shown_value() != int'(lab1_pkg::LFSR_SEED)) begin
			$display("ERROR %s: expected %0d, actual %0d", test_name,
				lab1_pkg::LFSR_SEED, shown_value());
			errors++;
		end
		if ($countones(o_ledr) != 1) begin
			$display("ERROR %s: expected 1, actual %0d", test_name, $countones(o_ledr));
			errors++;
		end
		if (o_ledg[3:0] != 4'b0001) begin
			$display("ERROR %s: expected 0001, actual %b", test_name, o_ledg[3:0]);
			errors++;
		end
		if (o_ledg[8] != 1'b0) begin
			$display("ERROR %s: expected 0, actual %b", test_name, o_ledg[8]);
			errors++;
		end
		end_test();
	endtask

	task automatic test_glitch();
		int start_val;
		int start_changes;
		int len;
		int used;
		begin_test("glitch");
		start_val     = last_val;
		start_changes = changes;
		used          = 0;
		for (int n = 0; n < 8; n++) begin
			len = $urandom_range(DEBOUNCE_LEN - 1, 1);
			set_key(n[0], 1'b0);
			repeat (len) step_cycle();
			set_key(n[0], 1'b1);
			repeat (6) step_cycle();
			used += len + 6;
		end
		repeat (GLITCH_WATCH - used) step_cycle();
		if (changes != start_changes || last_val != start_val) begin
			$display("ERROR %s: expected %0d, actual %0d", test_name, start_val, last_val);
			errors++;
		end
		if (o_ledg[3:0] != 4'b0001) begin
			$display("ERROR %s: expected 0001, actual %b", test_name, o_ledg[3:0]);
			errors++;
		end
		end_test();
	endtask

	task automatic full_run(input string name, input bit do_hold);
		int  start_val;
		int  start_changes;
		int  start_toggles;
		int  exp_val;
		bit  ok;
		begin_test(name);
		start_val     = last_val;
		start_changes = changes;
		start_toggles = toggles;
		press_key(1'b0);
		wait_state(2, RUN_LEN + 4 * DEBOUNCE_LEN, ok);
		if (!ok) begin
			$display("%s: roller never reached the done state", test_name);
			errors++;
		end
		if (changes - start_changes != STEP_COUNT) begin
			$display("ERROR %s: expected %0d, actual %0d", test_name, STEP_COUNT,
				changes - start_changes);
			errors++;
		end
		if (toggles == start_toggles) begin
			$display("%s: run blinker never toggled", test_name);
			errors++;
		end
		exp_val = start_val;
		for (int k = 0; k < STEP_COUNT; k++) exp_val = next_value(exp_val);
		if (last_val != exp_val) begin
			$display("ERROR %s: expected %0d, actual %0d", test_name, exp_val, last_val);
			errors++;
		end
		if (do_hold) begin
			repeat (HOLD_CYCLES) step_cycle();
			if (last_val != exp_val || changes - start_changes != STEP_COUNT) begin
				$display("ERROR %s: expected %0d, actual %0d", test_name, exp_val, last_val);
				errors++;
			end
			if (o_ledg[3:0] != 4'b0100) begin
				$display("ERROR %s: expected 0100, actual %b", test_name, o_ledg[3:0]);
				errors++;
			end
			if (o_ledg[8] != 1'b0) begin
				$display("ERROR %s: expected 0, actual %b", test_name, o_ledg[8]);
				errors++;
			end
		end
		end_test();
	endtask

	task automatic test_stop();
		int start_changes;
		int hold_val;
		int hold_changes;
		bit ok;
		begin_test("stop");
		start_changes = changes;
		press_key(1'b0);
		for (int n = 0; n < RUN_LEN && changes - start_changes < 3; n++) step_cycle();
		press_key(1'b1);
		wait_state(3, 4 * DEBOUNCE_LEN, ok);
		if (!ok) begin
			$display("%s: roller did not enter the stop state", test_name);
			errors++;
		end
		hold_val     = last_val;
		hold_changes = changes;
		repeat (GLITCH_WATCH) step_cycle();
		if (changes != hold_changes) begin
			$display("ERROR %s: expected %0d, actual %0d", test_name, hold_val, last_val);
			errors++;
		end
		if (o_ledg[3:0] != 4'b1000) begin
			$display("ERROR %s: expected 1000, actual %b", test_name, o_ledg[3:0]);
			errors++;
		end
		if (o_ledg[8] != 1'b0) begin
			$display("ERROR %s: expected 0, actual %b", test_name, o_ledg[8]);
			errors++;
		end
		end_test();
	endtask

	initial begin
		void'($urandom(32'h3437_68e0));
		i_rst_n     = 1'b0;
		i_key_start = 1'b1;
		i_key_stop  = 1'b1;
		repeat (8) @(negedge i_clk);
		i_rst_n    = 1'b1;
		last_val   = shown_value();
		last_blink = o_ledg[8];
		step_cycle();
		test_reset();
		test_glitch();
		watch_on = 1'b1;
		full_run("full_run", 1'b1);
		test_stop();
		full_run("restart", 1'b0);
		$display("tests run: %0d, tests failed: %0d, errors: %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== rtl/de2_115_lab1.sv ====
`timescale 1ns/1ps

module de2_115_lab1 #(
	parameter int DEBOUNCE_LEN  = 500_000,   // 10 ms at 50 MHz
	parameter int BASE_INTERVAL = 1_000_000, // 20 ms per step increment
	parameter int STEP_COUNT    = 20,
	parameter int BLINK_HALF    = 6_250_000  // 4 Hz blink
) (
	input  logic           i_clk,
	input  logic           i_rst_n,
	input  logic           i_key_start,
	input  logic           i_key_stop,
	output lab1_pkg::seg_t o_hex0,
	output lab1_pkg::seg_t o_hex1,
	output logic [8:0]     o_ledg,
	output logic [17:0]    o_ledr
);

	logic                  start_pulse;
	logic                  stop_pulse;
	lab1_pkg::rand_t       random_value;
	lab1_pkg::roll_state_t state_value;

	debounce #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) deb_start (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_in    (i_key_start),
		.o_neg   (start_pulse)
	);

	debounce #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) deb_stop (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_in    (i_key_stop),
		.o_neg   (stop_pulse)
	);

	rand_roller #(
		.BASE_INTERVAL (BASE_INTERVAL),
		.STEP_COUNT    (STEP_COUNT)
	) roller (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_start      (start_pulse),
		.i_stop       (stop_pulse),
		.o_random_out (random_value),
		.o_state      (state_value)
	);

	seven_hex_decoder seven_dec (
		.i_hex       (random_value),
		.o_seven_ten (o_hex1),
		.o_seven_one (o_hex0)
	);

	led_display #(.BLINK_HALF(BLINK_HALF)) led (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_state      (state_value),
		.i_random_out (random_value),
		.o_ledg       (o_ledg),
		.o_ledr       (o_ledr)
	);

endmodule

// ==== rtl/led_display.sv ====
`timescale 1ns/1ps

module led_display #(
	parameter int BLINK_HALF = 5
) (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  lab1_pkg::roll_state_t i_state,
	input  lab1_pkg::rand_t       i_random_out,
	output logic [8:0]            o_ledg,
	output logic [17:0]           o_ledr
);

	localparam int BLK_W = (BLINK_HALF > 1) ? $clog2(BLINK_HALF) : 1;

	logic [BLK_W-1:0] half_q;
	logic             blink_q;

	// red bar, one LED per unit of value
	always_comb begin
		for (int i = 0; i < 18; i++) begin
			o_ledr[i] = (i < int'(i_random_out));
		end
	end

	always_comb begin
		o_ledg[3:0] = 4'b0000;
		case (i_state)
			lab1_pkg::ST_IDLE: o_ledg[0] = 1'b1;
			lab1_pkg::ST_RUN:  o_ledg[1] = 1'b1;
			lab1_pkg::ST_DONE: o_ledg[2] = 1'b1;
			lab1_pkg::ST_STOP: o_ledg[3] = 1'b1;
			default:           o_ledg[3:0] = 4'b0000;
		endcase
		o_ledg[7:4] = 4'b0000;
		o_ledg[8]   = blink_q;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n || i_state != lab1_pkg::ST_RUN) begin
			half_q  <= '0;
			blink_q <= 1'b0; // dark outside run
		end else if (half_q == BLK_W'(BLINK_HALF - 1)) begin
			half_q  <= '0;
			blink_q <= ~blink_q;
		end else begin
			half_q <= half_q + 1'b1;
		end
	end

	a_state_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot(o_ledg[3:0]));

endmodule

// ==== rtl/seven_hex_decoder.sv ====
`timescale 1ns/1ps

module seven_hex_decoder (
	input  lab1_pkg::rand_t i_hex,
	output lab1_pkg::seg_t  o_seven_ten,
	output lab1_pkg::seg_t  o_seven_one
);

	logic       tens;
	logic [3:0] ones;

	function automatic lab1_pkg::seg_t seg_of(input logic [3:0] digit);
		lab1_pkg::seg_t seg;
		case (digit)
			4'd0:    seg = 7'b1000000;
			4'd1:    seg = 7'b1111001;
			4'd2:    seg = 7'b0100100;
			4'd3:    seg = 7'b0110000;
			4'd4:    seg = 7'b0011001;
			4'd5:    seg = 7'b0010010;
			4'd6:    seg = 7'b0000010;
			4'd7:    seg = 7'b1111000;
			4'd8:    seg = 7'b0000000;
			4'd9:    seg = 7'b0010000;
			default: seg = 7'b1111111; // blank
		endcase
		return seg;
	endfunction

	// value never exceeds 15, so tens is 0 or 1
	assign tens = (i_hex >= 4'd10);
	assign ones = tens ? i_hex - 4'd10 : i_hex;

	assign o_seven_ten = seg_of({3'b000, tens});
	assign o_seven_one = seg_of(ones);

endmodule

// ==== rtl/rand_roller.sv ====
`timescale 1ns/1ps

module rand_roller #(
	parameter int BASE_INTERVAL = 3,
	parameter int STEP_COUNT    = 10
) (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_start,
	input  logic                  i_stop,
	output lab1_pkg::rand_t       o_random_out,
	output lab1_pkg::roll_state_t o_state
);

	localparam int STEP_W = $clog2(STEP_COUNT + 1);
	// target runs one step past the last one before the FSM leaves run
	localparam int TGT_W  = $clog2((STEP_COUNT + 1) * BASE_INTERVAL + 1);

	lab1_pkg::roll_state_t state_q;
	lab1_pkg::rand_t       lfsr_q;
	lab1_pkg::rand_t       lfsr_next;
	logic [STEP_W-1:0]     step_q;
	logic [TGT_W-1:0]      wait_q;
	logic [TGT_W-1:0]      target_q;
	logic                  step_due;
	logic                  last_step;

	assign lfsr_next = {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
	assign step_due  = (wait_q == target_q - TGT_W'(1));
	assign last_step = (step_q == STEP_W'(STEP_COUNT - 1));

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_q  <= lab1_pkg::ST_IDLE;
			lfsr_q   <= lab1_pkg::LFSR_SEED;
			step_q   <= '0;
			wait_q   <= '0;
			target_q <= '0;
		end else begin
			case (state_q)
				lab1_pkg::ST_RUN: begin
					if (i_stop) begin
						state_q <= lab1_pkg::ST_STOP; // value freezes as is
					end else if (step_due) begin
						lfsr_q   <= lfsr_next;
						wait_q   <= '0;
						target_q <= target_q + TGT_W'(BASE_INTERVAL); // longer wait each step
						step_q   <= step_q + 1'b1;
						if (last_step) begin
							state_q <= lab1_pkg::ST_DONE;
						end
					end else begin
						wait_q <= wait_q + 1'b1;
					end
				end
				default: begin
					// idle, done and stop all restart on a start press
					if (i_start) begin
						state_q  <= lab1_pkg::ST_RUN;
						step_q   <= '0;
						wait_q   <= '0;
						target_q <= TGT_W'(BASE_INTERVAL);
					end
				end
			endcase
		end
	end

	assign o_random_out = lfsr_q;
	assign o_state      = state_q;

	a_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_random_out != '0);

	a_change_in_run: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$changed(o_random_out) |-> $past(o_state) == lab1_pkg::ST_RUN);

endmodule

// ==== rtl/debounce.sv ====
`timescale 1ns/1ps

module debounce #(
	parameter int DEBOUNCE_LEN = 4
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_in,
	output logic o_neg
);

	localparam int CNT_W = (DEBOUNCE_LEN > 1) ? $clog2(DEBOUNCE_LEN + 1) : 1;

	logic [CNT_W-1:0] cnt_q;
	logic             level_q;
	logic             level_d_q;
	logic             neg_q;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			cnt_q   <= '0;
			level_q <= 1'b1; // released key reads high
		end else if (i_in != level_q) begin
			if (cnt_q == CNT_W'(DEBOUNCE_LEN - 1)) begin
				level_q <= i_in;
				cnt_q   <= '0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end else begin
			cnt_q <= '0; // sample went back, start over
		end
	end

	// falling edge of the filtered level
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			level_d_q <= 1'b1;
			neg_q     <= 1'b0;
		end else begin
			level_d_q <= level_q;
			neg_q     <= level_d_q & ~level_q;
		end
	end

	assign o_neg = neg_q;

	a_neg_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_neg |=> !o_neg);

endmodule

// ==== rtl/lab1_pkg.sv ====
package lab1_pkg;

	// rolled value, 1 to 15, never zero
	typedef logic [3:0] rand_t;

	// seven-segment pattern, active low, bit 0 = a ... bit 6 = g
	typedef logic [6:0] seg_t;

	typedef enum logic [2:0] {
		ST_IDLE = 3'd0,
		ST_RUN  = 3'd1,
		ST_DONE = 3'd2,
		ST_STOP = 3'd3
	} roll_state_t;

	// x^4 + x^3 + 1 sequence, any nonzero start works
	localparam rand_t LFSR_SEED = 4'd1;

endpackage
